//--- verilog/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first fetch address after reset
`define CPU_RESET_PC 16'h4000

`define CPU_WORD_W 16
`define CPU_BYTE_W 8

// one byte
`define OP_NOP 8'h00
`define OP_LD_XL_IY 8'h01
`define OP_LD_IY_XL 8'h02
`define OP_TRAP 8'h03

// two bytes with an immediate or a displacement as the second
`define OP_LD_XL_IMMD 8'h10
`define OP_ADD_XL_IMMD 8'h11
`define OP_SUB_XL_IMMD 8'h12
`define OP_AND_XL_IMMD 8'h13
`define OP_OR_XL_IMMD 8'h14
`define OP_XOR_XL_IMMD 8'h15
`define OP_JR_D 8'h20
`define OP_JRZ_D 8'h21
`define OP_JRNZ_D 8'h22
`define OP_JRC_D 8'h23
`define OP_JRNC_D 8'h24

// three bytes with a little-endian address or word
`define OP_LD_XL_DIR 8'h30
`define OP_LD_DIR_XL 8'h31
`define OP_LDW_Y_IMMD 8'h32
`define OP_JP_IMMD 8'h33

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`CPU_BYTE_W-1:0] byte_t;
	typedef logic [`CPU_WORD_W-1:0] word_t;

	// word index into one byte bank
	typedef logic [`CPU_WORD_W-2:0] bank_addr_t;

	typedef enum logic [2:0]
	{
		FLAG_H = 3'd0,
		FLAG_C = 3'd1,
		FLAG_N = 3'd2,
		FLAG_Z = 3'd3,
		FLAG_O = 3'd4
	} flag_index_t;

	typedef logic [4:0] flags_t;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS
	} alu_op_t;

endpackage

//--- verilog/alu8.sv
`timescale 1ns/1ps

module alu8 import cpu_pkg::*;
(
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	input flags_t flags_in,
	output byte_t result,
	output flags_t flags_out
);
	byte_t b_eff;
	logic carry_in;
	logic [8:0] sum;
	logic [4:0] half_sum;

	// subtract as a + ~b + 1, so carry set means no borrow
	assign b_eff = (op == ALU_SUB) ? ~b : b;
	assign carry_in = op == ALU_SUB;
	assign sum = {1'b0, a} + {1'b0, b_eff} + {8'h00, carry_in};
	assign half_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'h0, carry_in};

	always_comb
	begin
		case (op)
			ALU_ADD, ALU_SUB: result = sum[7:0];
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			default: result = b;
		endcase
	end

	always_comb
	begin
		flags_out = flags_in;
		flags_out[FLAG_Z] = result == 8'h00;
		flags_out[FLAG_N] = result[7];
		if (op == ALU_ADD || op == ALU_SUB)
		begin
			flags_out[FLAG_C] = sum[8];
			flags_out[FLAG_H] = half_sum[4];
			flags_out[FLAG_O] = (a[7] == b_eff[7]) && (sum[7] != a[7]);
		end
	end

endmodule

//--- verilog/mem_lanes.sv
`timescale 1ns/1ps

module mem_lanes import cpu_pkg::*;
(
	input logic clk,
	input word_t read_addr,
	input byte_t read_data_even,
	input byte_t read_data_odd,
	output word_t read_word,
	input word_t write_addr,
	input byte_t write_data,
	input logic write_en,
	output bank_addr_t read_addr_even,
	output bank_addr_t read_addr_odd,
	output bank_addr_t write_addr_even,
	output bank_addr_t write_addr_odd,
	output byte_t write_data_even,
	output byte_t write_data_odd,
	output logic write_en_even,
	output logic write_en_odd
);
	logic read_odd_q;

	// odd start takes the even byte from the next word
	assign read_addr_odd = read_addr[15:1];
	assign read_addr_even = read_addr[0] ? read_addr[15:1] + 15'd1 : read_addr[15:1];

	always_ff @(posedge clk)
	begin
		read_odd_q <= read_addr[0];
	end

	assign read_word = read_odd_q ? {read_data_even, read_data_odd} :
		{read_data_odd, read_data_even};

	assign write_addr_even = write_addr[15:1];
	assign write_addr_odd = write_addr[15:1];
	assign write_data_even = write_data;
	assign write_data_odd = write_data;
	assign write_en_even = write_en && !write_addr[0];
	assign write_en_odd = write_en && write_addr[0];

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic write_sel,
	input logic [1:0] write_en,
	input word_t write_data,
	input flags_t next_flags,
	output word_t x,
	output word_t y,
	output flags_t flags
);
	// entry 0 is x, entry 1 is y
	word_t regs [2];

	assign x = regs[0];
	assign y = regs[1];

	always_ff @(posedge clk)
	begin
		if (write_en[0])
			regs[write_sel][7:0] <= write_data[7:0];
		if (write_en[1])
			regs[write_sel][15:8] <= write_data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

//--- verilog/program_counter.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module program_counter import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic execute,
	input byte_t inst_opcode,
	input word_t inst_arg,
	input word_t operand,
	input flags_t flags,
	output logic trap,
	output word_t pc,
	output word_t next_pc
);
	word_t inst_size;
	logic taken;

	assign trap = inst_opcode == `OP_TRAP;

	always_comb
	begin
		if (inst_opcode >= `OP_LD_XL_DIR && inst_opcode <= `OP_JP_IMMD)
			inst_size = 16'd3;
		else if (inst_opcode >= `OP_LD_XL_IMMD && inst_opcode <= `OP_XOR_XL_IMMD ||
			inst_opcode >= `OP_JR_D && inst_opcode <= `OP_JRNC_D)
			inst_size = 16'd2;
		else
			inst_size = 16'd1;
	end

	assign taken = inst_opcode == `OP_JR_D ||
		inst_opcode == `OP_JRZ_D && flags[FLAG_Z] || inst_opcode == `OP_JRNZ_D && !flags[FLAG_Z] ||
		inst_opcode == `OP_JRC_D && flags[FLAG_C] || inst_opcode == `OP_JRNC_D && !flags[FLAG_C];

	always_comb
	begin
		if (reset)
			next_pc = `CPU_RESET_PC;
		else if (!execute || trap)
			next_pc = pc;
		else if (inst_opcode == `OP_JP_IMMD)
			next_pc = operand;
		else if (taken)
			next_pc = pc + {{8{inst_arg[7]}}, inst_arg[7:0]};
		else
			next_pc = pc + inst_size;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `CPU_RESET_PC;
		else
			pc <= next_pc;
	end

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module execute_unit import cpu_pkg::*;
(
	input logic execute,
	input byte_t inst_opcode,
	input word_t inst_arg,
	input word_t operand,
	input word_t x,
	input word_t y,
	input flags_t flags,
	output logic write_sel,
	output logic [1:0] write_en,
	output word_t write_data,
	output flags_t next_flags,
	output word_t mem_write_addr,
	output byte_t mem_write_data,
	output logic mem_write_en
);
	alu_op_t alu_op;
	byte_t alu_b;
	byte_t alu_result;
	flags_t alu_flags;

	alu8 alu8_i
	(
		.op(alu_op),
		.a(x[7:0]),
		.b(alu_b),
		.flags_in(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	// loaded byte for memory reads and the second instruction byte otherwise
	assign alu_b = (inst_opcode == `OP_LD_XL_DIR || inst_opcode == `OP_LD_XL_IY) ?
		operand[7:0] : inst_arg[7:0];

	always_comb
	begin
		case (inst_opcode)
			`OP_ADD_XL_IMMD: alu_op = ALU_ADD;
			`OP_SUB_XL_IMMD: alu_op = ALU_SUB;
			`OP_AND_XL_IMMD: alu_op = ALU_AND;
			`OP_OR_XL_IMMD: alu_op = ALU_OR;
			`OP_XOR_XL_IMMD: alu_op = ALU_XOR;
			default: alu_op = ALU_PASS;
		endcase
	end

	always_comb
	begin
		write_sel = 1'b0;
		write_en = 2'b00;
		write_data = {alu_result, alu_result};
		next_flags = flags;
		mem_write_addr = inst_arg;
		mem_write_data = x[7:0];
		mem_write_en = 1'b0;
		if (execute)
		begin
			case (inst_opcode)
				// immediate load leaves the flags alone
				`OP_LD_XL_IMMD:
					write_en = 2'b01;
				`OP_ADD_XL_IMMD, `OP_SUB_XL_IMMD, `OP_AND_XL_IMMD, `OP_OR_XL_IMMD,
				`OP_XOR_XL_IMMD, `OP_LD_XL_DIR, `OP_LD_XL_IY:
				begin
					write_en = 2'b01;
					next_flags = alu_flags;
				end
				`OP_LDW_Y_IMMD:
				begin
					write_sel = 1'b1;
					write_en = 2'b11;
					write_data = operand;
				end
				`OP_LD_DIR_XL:
					mem_write_en = 1'b1;
				`OP_LD_IY_XL:
				begin
					mem_write_addr = y;
					mem_write_en = 1'b1;
				end
				default:
					write_en = 2'b00;
			endcase
		end
	end

endmodule

//--- verilog/cpu_control.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_control import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t pc,
	input word_t next_pc,
	input word_t y,
	input word_t read_word,
	output word_t read_addr,
	output byte_t inst_opcode,
	output word_t inst_arg,
	output word_t operand,
	output logic execute
);
	logic [23:0] inst;
	logic [23:0] inst_q;
	logic upper_pending;
	logic operand_pending;
	logic needs_upper;
	logic needs_operand;
	logic have_upper;
	logic fetch_upper;
	logic fetch_operand;
	word_t operand_addr;

	always_comb
	begin
		if (reset)
			inst = {16'h0000, `OP_NOP};
		else if (upper_pending)
			inst = {read_word[7:0], inst_q[15:0]};
		else if (operand_pending)
			inst = inst_q;
		else
			inst = {8'h00, read_word};
	end

	assign inst_opcode = inst[7:0];
	assign inst_arg = inst[23:8];
	// only meaningful while an operand read returns
	assign operand = read_word;

	assign needs_upper = inst_opcode == `OP_LD_XL_DIR || inst_opcode == `OP_LD_DIR_XL;
	assign needs_operand = inst_opcode == `OP_LD_XL_DIR || inst_opcode == `OP_LD_XL_IY ||
		inst_opcode == `OP_LDW_Y_IMMD || inst_opcode == `OP_JP_IMMD;

	// latched instruction already holds byte 2 once an operand is pending
	assign have_upper = !needs_upper || upper_pending || operand_pending;
	assign execute = have_upper && (!needs_operand || operand_pending);
	assign fetch_upper = !have_upper;
	assign fetch_operand = have_upper && needs_operand && !operand_pending;

	always_comb
	begin
		if (inst_opcode == `OP_LD_XL_DIR)
			operand_addr = inst[23:8];
		else if (inst_opcode == `OP_LD_XL_IY)
			operand_addr = y;
		else
			operand_addr = pc + 16'd1;
	end

	always_comb
	begin
		if (fetch_upper)
			read_addr = pc + 16'd2;
		else if (fetch_operand)
			read_addr = operand_addr;
		else
			read_addr = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			upper_pending <= 1'b0;
			operand_pending <= 1'b0;
		end
		else
		begin
			upper_pending <= fetch_upper;
			operand_pending <= fetch_operand;
		end
	end

	always_ff @(posedge clk)
	begin
		inst_q <= inst;
	end

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	output bank_addr_t mem_read_addr_even,
	output bank_addr_t mem_read_addr_odd,
	input byte_t mem_read_data_even,
	input byte_t mem_read_data_odd,
	output bank_addr_t mem_write_addr_even,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_even,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);
	word_t pc;
	word_t next_pc;
	word_t read_addr;
	word_t read_word;
	byte_t inst_opcode;
	word_t inst_arg;
	word_t operand;
	logic execute;
	word_t x;
	word_t y;
	flags_t flags;
	flags_t next_flags;
	logic reg_write_sel;
	logic [1:0] reg_write_en;
	word_t reg_write_data;
	word_t mem_write_addr;
	byte_t mem_write_data;
	logic mem_write_en;

	cpu_control cpu_control_i
	(
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.next_pc(next_pc),
		.y(y),
		.read_word(read_word),
		.read_addr(read_addr),
		.inst_opcode(inst_opcode),
		.inst_arg(inst_arg),
		.operand(operand),
		.execute(execute)
	);

	program_counter program_counter_i
	(
		.clk(clk),
		.reset(reset),
		.execute(execute),
		.inst_opcode(inst_opcode),
		.inst_arg(inst_arg),
		.operand(operand),
		.flags(flags),
		.trap(trap),
		.pc(pc),
		.next_pc(next_pc)
	);

	register_file register_file_i
	(
		.clk(clk),
		.reset(reset),
		.write_sel(reg_write_sel),
		.write_en(reg_write_en),
		.write_data(reg_write_data),
		.next_flags(next_flags),
		.x(x),
		.y(y),
		.flags(flags)
	);

	execute_unit execute_unit_i
	(
		.execute(execute),
		.inst_opcode(inst_opcode),
		.inst_arg(inst_arg),
		.operand(operand),
		.x(x),
		.y(y),
		.flags(flags),
		.write_sel(reg_write_sel),
		.write_en(reg_write_en),
		.write_data(reg_write_data),
		.next_flags(next_flags),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_en(mem_write_en)
	);

	mem_lanes mem_lanes_i
	(
		.clk(clk),
		.read_addr(read_addr),
		.read_data_even(mem_read_data_even),
		.read_data_odd(mem_read_data_odd),
		.read_word(read_word),
		.write_addr(mem_write_addr),
		.write_data(mem_write_data),
		.write_en(mem_write_en),
		.read_addr_even(mem_read_addr_even),
		.read_addr_odd(mem_read_addr_odd),
		.write_addr_even(mem_write_addr_even),
		.write_addr_odd(mem_write_addr_odd),
		.write_data_even(mem_write_data_even),
		.write_data_odd(mem_write_data_odd),
		.write_en_even(mem_write_en_even),
		.write_en_odd(mem_write_en_odd)
	);

endmodule

//--- testbench/cpu_props.sv
`timescale 1ns/1ps

module cpu_props
(
	input logic clk,
	input logic reset,
	input logic mem_write_en_even,
	input logic mem_write_en_odd,
	input logic trap
);
	// first cycle out of reset is quiet
	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !mem_write_en_even && !mem_write_en_odd && !trap)
		else $error("write enable or trap active right after reset");

	one_lane: assert property (@(posedge clk) !(mem_write_en_even && mem_write_en_odd))
		else $error("both byte lanes written in the same cycle");

	// only a reset releases a trapped core
	trap_holds: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
		else $error("trap dropped without a reset");

endmodule

bind cpu_top cpu_props cpu_props_i
(
	.clk(clk),
	.reset(reset),
	.mem_write_en_even(mem_write_en_even),
	.mem_write_en_odd(mem_write_en_odd),
	.trap(trap)
);

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*;
();
	localparam int NUM_ROWS = 18;
	localparam int CYCLE_LIMIT = NUM_ROWS * 40 + 10;

	logic clk;
	logic reset = 1'b1;
	bank_addr_t mem_read_addr_even;
	bank_addr_t mem_read_addr_odd;
	byte_t mem_read_data_even = 8'h00;
	byte_t mem_read_data_odd = 8'h00;
	bank_addr_t mem_write_addr_even;
	bank_addr_t mem_write_addr_odd;
	byte_t mem_write_data_even;
	byte_t mem_write_data_odd;
	logic mem_write_en_even;
	logic mem_write_en_odd;
	logic trap;

	byte_t mem_even [32768];
	byte_t mem_odd [32768];
	word_t log_addr [$];
	byte_t log_data [$];

	string row_name [NUM_ROWS];
	int row_offset [NUM_ROWS];
	logic [95:0] row_code [NUM_ROWS];
	int row_len [NUM_ROWS];
	word_t row_pre_addr [NUM_ROWS];
	byte_t row_pre_data [NUM_ROWS];
	word_t row_st_addr [NUM_ROWS];
	byte_t row_st_data [NUM_ROWS];
	int num_rows = 0;

	int error_count = 0;
	int check_count = 0;
	int cycles = 0;

	cpu_top cpu_top_i
	(
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// two byte banks with read data one cycle after the address
	always @(posedge clk)
	begin
		mem_read_data_even <= mem_even[mem_read_addr_even];
		mem_read_data_odd <= mem_odd[mem_read_addr_odd];
		if (mem_write_en_even)
		begin
			mem_even[mem_write_addr_even] = mem_write_data_even;
			log_addr.push_back({mem_write_addr_even, 1'b0});
			log_data.push_back(mem_write_data_even);
		end
		if (mem_write_en_odd)
		begin
			mem_odd[mem_write_addr_odd] = mem_write_data_odd;
			log_addr.push_back({mem_write_addr_odd, 1'b1});
			log_data.push_back(mem_write_data_odd);
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles: the core never reached trap", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	function automatic byte_t alu_expect(input byte_t op, input byte_t a, input byte_t b);
		case (op)
			`OP_ADD_XL_IMMD: return byte_t'(a + b);
			`OP_SUB_XL_IMMD: return byte_t'(a - b);
			`OP_AND_XL_IMMD: return a & b;
			`OP_OR_XL_IMMD: return a | b;
			`OP_XOR_XL_IMMD: return a ^ b;
			default: return 8'h00;
		endcase
	endfunction

	// Z on equal and C without a borrow after a - b
	function automatic logic branch_taken(input byte_t op, input byte_t a, input byte_t b);
		logic zero;
		logic no_borrow;
		zero = a == b;
		no_borrow = a >= b;
		case (op)
			`OP_JRZ_D: return zero;
			`OP_JRNZ_D: return !zero;
			`OP_JRC_D: return no_borrow;
			default: return !no_borrow;
		endcase
	endfunction

	task automatic add_row(input string name, input int offset, input logic [95:0] code,
		input int len, input word_t pre_addr, input byte_t pre_data, input word_t st_addr,
		input byte_t st_data);
		row_name[num_rows] = name;
		row_offset[num_rows] = offset;
		row_code[num_rows] = code;
		row_len[num_rows] = len;
		row_pre_addr[num_rows] = pre_addr;
		row_pre_data[num_rows] = pre_data;
		row_st_addr[num_rows] = st_addr;
		row_st_data[num_rows] = st_data;
		num_rows++;
	endtask

	task automatic build_table;
		byte_t a;
		byte_t b;
		byte_t op;
		word_t sa;
		for (int i = 0; i < 5; i++)
		begin
			a = byte_t'($urandom);
			b = byte_t'($urandom);
			op = byte_t'(`OP_ADD_XL_IMMD + i);
			sa = word_t'(16'h2000 + i);
			add_row($sformatf("alu_%02h", op), 0, 96'({`OP_LD_XL_IMMD, a, op, b,
				`OP_LD_DIR_XL, sa[7:0], sa[15:8], `OP_TRAP}), 8, 16'h3f00, 8'h00, sa,
				alu_expect(op, a, b));
		end
		// first pass of each branch with equal operands
		for (int k = 0; k < 8; k++)
		begin
			a = byte_t'($urandom);
			b = (k < 4) ? a : byte_t'($urandom);
			op = byte_t'(`OP_JRZ_D + k % 4);
			sa = word_t'(16'h2100 + k);
			add_row($sformatf("branch_%02h", op), 0, 96'({`OP_LD_XL_IMMD, a, `OP_SUB_XL_IMMD, b,
				op, 8'h04, `OP_LD_XL_IMMD, 8'hee, `OP_LD_DIR_XL, sa[7:0], sa[15:8], `OP_TRAP}),
				12, 16'h3f00, 8'h00, sa, branch_taken(op, a, b) ? byte_t'(a - b) : 8'hee);
		end
		a = byte_t'($urandom);
		add_row("ld_iy_even", 0, 96'({`OP_LDW_Y_IMMD, 8'h00, 8'h30, `OP_LD_XL_IY,
			`OP_LD_DIR_XL, 8'h10, 8'h22, `OP_TRAP}), 8, 16'h3000, a, 16'h2210, a);
		a = byte_t'($urandom);
		add_row("ld_iy_odd", 0, 96'({`OP_LDW_Y_IMMD, 8'h01, 8'h30, `OP_LD_XL_IY,
			`OP_LD_DIR_XL, 8'h11, 8'h22, `OP_TRAP}), 8, 16'h3001, a, 16'h2211, a);
		a = byte_t'($urandom);
		add_row("ld_dir_odd_pc", 1, 96'({`OP_LD_XL_DIR, 8'h05, 8'h30, `OP_LD_DIR_XL,
			8'h12, 8'h22, `OP_TRAP}), 7, 16'h3005, a, 16'h2212, a);
		a = byte_t'($urandom);
		add_row("st_iy", 0, 96'({`OP_LDW_Y_IMMD, 8'h13, 8'h22, `OP_LD_XL_IMMD, a,
			`OP_LD_IY_XL, `OP_TRAP}), 7, 16'h3f00, 8'h00, 16'h2213, a);
		a = byte_t'($urandom);
		// jump lands past the store to 0x00f0
		add_row("jp_skip", 0, 96'({`OP_LD_XL_IMMD, a, `OP_JP_IMMD, 8'h08, 8'h40,
			`OP_LD_DIR_XL, 8'hf0, 8'h00, `OP_LD_DIR_XL, 8'h14, 8'h22, `OP_TRAP}), 12,
			16'h3f00, 8'h00, 16'h2214, a);
	endtask

	task automatic put_byte(input word_t addr, input byte_t data);
		if (addr[0])
			mem_odd[addr[15:1]] = data;
		else
			mem_even[addr[15:1]] = data;
	endtask

	task automatic load_memory(input int r);
		word_t addr;
		for (int i = 0; i < 65536; i++)
		begin
			addr = word_t'(i);
			put_byte(addr, addr[7:0] ^ addr[15:8] ^ 8'h5c);
		end
		// trap padding catches a runaway pc
		for (int i = 0; i < 16; i++)
			put_byte(word_t'(16'h4000 + i), `OP_TRAP);
		for (int i = 0; i < row_offset[r]; i++)
			put_byte(word_t'(16'h4000 + i), `OP_NOP);
		for (int i = 0; i < row_len[r]; i++)
			put_byte(word_t'(16'h4000 + row_offset[r] + i),
				row_code[r][8 * (row_len[r] - 1 - i) +: 8]);
		put_byte(row_pre_addr[r], row_pre_data[r]);
		log_addr.delete();
		log_data.delete();
	endtask

	task automatic run_row(input int r);
		word_t held;
		word_t held_even;
		int errors_before;
		int writes;
		errors_before = error_count;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		load_memory(r);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_addr("mem_read_addr_even", 16'h2000, word_t'(mem_read_addr_even));
		check_addr("mem_read_addr_odd", 16'h2000, word_t'(mem_read_addr_odd));
		check_bit("trap", 1'b0, trap);
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		while (trap !== 1'b1)
			@(negedge clk);
		writes = log_addr.size();
		if (writes != 1)
		begin
			$display("error at %0t: %0d memory writes before trap instead of one", $time, writes);
			error_count++;
		end
		else
		begin
			check_addr("store address", row_st_addr[r], log_addr[0]);
			check_byte("store data", row_st_data[r], log_data[0]);
		end
		held = word_t'(mem_read_addr_odd);
		held_even = word_t'(mem_read_addr_even);
		repeat (4)
		begin
			@(negedge clk);
			check_bit("trap", 1'b1, trap);
			check_addr("mem_read_addr_even", held_even, word_t'(mem_read_addr_even));
			check_addr("mem_read_addr_odd", held, word_t'(mem_read_addr_odd));
		end
		if (log_addr.size() != writes)
		begin
			$display("error at %0t: memory was written while the core was trapped", $time);
			error_count++;
		end
		$display("%s: %s", row_name[r], (error_count == errors_before) ? "passed" : "failed");
	endtask

	initial
	begin
		void'($urandom(32'h2b49_87a8));
		build_table();
		for (int r = 0; r < num_rows; r++)
			run_row(r);
		$display("rows %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu8.sv
verilog/mem_lanes.sv
verilog/register_file.sv
verilog/program_counter.sv
verilog/execute_unit.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
